// ==== files.f ====
+incdir+verification
hdl/rf_cmd_pkg.sv
hdl/rf_timing_pkg.sv
hdl/wait_timer.sv
hdl/cmd_parser.sv
hdl/reply_sequencer.sv
hdl/rf_program_ctrl.sv
verification/tb_rf_program_ctrl.sv

// ==== hdl/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser
    import rf_cmd_pkg::*;
(
    input  logic        mode3_clk,
    input  logic        rst_n,
    input  logic        m0,
    input  logic        m1,
    input  logic        rx_valid,
    input  byte_t       rx_data,
    input  logic        seq_busy,
    output logic        req,
    output reply_kind_t req_kind,
    output byte_t       head,
    output byte_t       addh,
    output byte_t       addl,
    output byte_t       sped,
    output byte_t       chan,
    output byte_t       option,
    output logic        cmd_busy
);

    typedef enum logic [3:0] {
        st_idle,
        st_load_addh,
        st_load_addl,
        st_load_sped,
        st_load_chan,
        st_load_option,
        st_cfg_2,
        st_cfg_3,
        st_ver_2,
        st_ver_3,
        st_rst_2,
        st_rst_3
    } state_t;

    state_t state;
    logic   mode3_en;
    logic   take;

    assign mode3_en = ({m1, m0} == mode_program);

    // Bytes are dropped while a reply is still running
    assign take = rx_valid && mode3_en && !seq_busy;

    assign cmd_busy = (state != st_idle);

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            req      <= 1'b0;
            req_kind <= reply_config;
            head     <= init_head;
            addh     <= init_addh;
            addl     <= init_addl;
            sped     <= init_sped;
            chan     <= init_chan;
            option   <= init_option;
        end else begin
            req <= 1'b0;
            if (!mode3_en) begin
                // Leaving mode 3 abandons a partial command
                state <= st_idle;
            end else if (take) begin
                case (state)
                    st_idle: begin
                        case (rx_data)
                            cmd_load_keep, cmd_load_temp: begin
                                head  <= rx_data;
                                state <= st_load_addh;
                            end
                            cmd_read_config:  state <= st_cfg_2;
                            cmd_read_version: state <= st_ver_2;
                            cmd_reset:        state <= st_rst_2;
                            default:          state <= st_idle;
                        endcase
                    end
                    st_load_addh: begin
                        addh  <= rx_data;
                        state <= st_load_addl;
                    end
                    st_load_addl: begin
                        addl  <= rx_data;
                        state <= st_load_sped;
                    end
                    st_load_sped: begin
                        sped  <= rx_data;
                        state <= st_load_chan;
                    end
                    st_load_chan: begin
                        chan  <= rx_data;
                        state <= st_load_option;
                    end
                    st_load_option: begin
                        // A load echoes the new configuration
                        option   <= rx_data;
                        state    <= st_idle;
                        req      <= 1'b1;
                        req_kind <= reply_config;
                    end
                    st_cfg_2: state <= (rx_data == cmd_read_config) ? st_cfg_3 : st_idle;
                    st_cfg_3: begin
                        state <= st_idle;
                        if (rx_data == cmd_read_config) begin
                            req      <= 1'b1;
                            req_kind <= reply_config;
                        end
                    end
                    st_ver_2: state <= (rx_data == cmd_read_version) ? st_ver_3 : st_idle;
                    st_ver_3: begin
                        state <= st_idle;
                        if (rx_data == cmd_read_version) begin
                            req      <= 1'b1;
                            req_kind <= reply_version;
                        end
                    end
                    st_rst_2: state <= (rx_data == cmd_reset) ? st_rst_3 : st_idle;
                    st_rst_3: begin
                        state <= st_idle;
                        if (rx_data == cmd_reset) begin
                            req      <= 1'b1;
                            req_kind <= reply_reset;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

// ==== hdl/reply_sequencer.sv ====
`timescale 1ns/1ps

module reply_sequencer
    import rf_cmd_pkg::*;
(
    input  logic        mode3_clk,
    input  logic        rst_n,
    input  logic        req,
    input  reply_kind_t req_kind,
    input  byte_t       head,
    input  byte_t       addh,
    input  byte_t       addl,
    input  byte_t       sped,
    input  byte_t       chan,
    input  byte_t       option,
    input  logic        cmd_busy,
    input  logic        process_done,
    input  logic        reset_done,
    input  logic        check_done,
    output logic        process_start,
    output logic        reset_start,
    output logic        check_start,
    output logic        tx_valid,
    output byte_t       tx_data,
    output logic        seq_busy,
    output logic        aux
);

    typedef enum logic [2:0] {
        st_idle,
        st_process,
        st_send,
        st_gap,
        st_reset_wait,
        st_self_check,
        st_done
    } state_t;

    state_t      state;
    reply_kind_t kind_q;
    logic [2:0]  idx;
    logic [2:0]  last_idx;

    // Four version bytes or six configuration bytes
    assign last_idx = (kind_q == reply_version) ? 3'd3 : 3'd5;

    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            kind_q <= reply_config;
            idx    <= 3'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        kind_q <= req_kind;
                        idx    <= 3'd0;
                        state  <= st_process;
                    end
                end
                st_process: begin
                    if (process_done) begin
                        state <= (kind_q == reply_reset) ? st_reset_wait : st_send;
                    end
                end
                st_send: begin
                    // The done cycle is the gap after the last byte
                    state <= (idx == last_idx) ? st_done : st_gap;
                end
                st_gap: begin
                    idx   <= idx + 3'd1;
                    state <= st_send;
                end
                st_reset_wait: begin
                    if (reset_done) begin
                        state <= st_self_check;
                    end
                end
                st_self_check: begin
                    if (check_done) begin
                        state <= st_done;
                    end
                end
                st_done:  state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // One timer per waiting state
    assign process_start = (state == st_process);
    assign reset_start   = (state == st_reset_wait);
    assign check_start   = (state == st_self_check);

    assign seq_busy = (state != st_idle);
    assign tx_valid = (state == st_send);

    // Reply byte for the current index
    always_comb begin
        tx_data = head;
        if (kind_q == reply_version) begin
            case (idx)
                3'd0:    tx_data = version_b0;
                3'd1:    tx_data = version_b1;
                3'd2:    tx_data = version_b2;
                default: tx_data = version_b3;
            endcase
        end else begin
            case (idx)
                3'd0:    tx_data = head;
                3'd1:    tx_data = addh;
                3'd2:    tx_data = addl;
                3'd3:    tx_data = sped;
                3'd4:    tx_data = chan;
                default: tx_data = option;
            endcase
        end
    end

    // aux goes high only once both sides are quiet
    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            aux <= 1'b1;
        end else begin
            aux <= !(cmd_busy || seq_busy);
        end
    end

endmodule

// ==== hdl/rf_cmd_pkg.sv ====
package rf_cmd_pkg;

    // One byte on the host UART
    typedef logic [7:0] byte_t;

    // What the sequencer does once the processing delay ends
    typedef enum logic [1:0] {
        reply_config,
        reply_version,
        reply_reset
    } reply_kind_t;

    // Host command head bytes
    localparam byte_t cmd_load_keep    = 8'hC0;
    localparam byte_t cmd_read_config  = 8'hC1;
    localparam byte_t cmd_load_temp    = 8'hC2;
    localparam byte_t cmd_read_version = 8'hC3;
    localparam byte_t cmd_reset        = 8'hC4;

    // Version reply starts with the format bytes
    localparam byte_t version_b0 = 8'hC3;
    localparam byte_t version_b1 = 8'h32;
    localparam byte_t version_b2 = 8'h27;
    localparam byte_t version_b3 = 8'h02;

    // Configuration after reset
    localparam byte_t init_head   = 8'h00;
    localparam byte_t init_addh   = 8'h00;
    localparam byte_t init_addl   = 8'h00;
    localparam byte_t init_sped   = 8'h18;  // 8N1, 9600 baud
    localparam byte_t init_chan   = 8'h00;
    localparam byte_t init_option = 8'h00;

    // {m1, m0} for programming mode
    localparam logic [1:0] mode_program = 2'd3;

endpackage

// ==== hdl/rf_program_ctrl.sv ====
`timescale 1ns/1ps

module rf_program_ctrl
    import rf_cmd_pkg::*;
    import rf_timing_pkg::*;
(
    input  logic  mode3_clk,
    input  logic  rst_n,
    input  logic  m0,
    input  logic  m1,
    input  logic  rx_valid,
    input  byte_t rx_data,
    output logic  tx_valid,
    output byte_t tx_data,
    output byte_t uart_config,
    output logic  aux
);

    logic        req;
    reply_kind_t req_kind;
    logic        cmd_busy;
    logic        seq_busy;
    byte_t       head;
    byte_t       addh;
    byte_t       addl;
    byte_t       sped;
    byte_t       chan;
    byte_t       option;
    logic        process_start;
    logic        process_done;
    logic        reset_start;
    logic        reset_done;
    logic        check_start;
    logic        check_done;

    // SPED sets the host UART format and baud rate
    assign uart_config = sped;

    cmd_parser u_cmd_parser (
        .mode3_clk (mode3_clk),
        .rst_n     (rst_n),
        .m0        (m0),
        .m1        (m1),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .seq_busy  (seq_busy),
        .req       (req),
        .req_kind  (req_kind),
        .head      (head),
        .addh      (addh),
        .addl      (addl),
        .sped      (sped),
        .chan      (chan),
        .option    (option),
        .cmd_busy  (cmd_busy)
    );

    reply_sequencer u_reply_sequencer (
        .mode3_clk     (mode3_clk),
        .rst_n         (rst_n),
        .req           (req),
        .req_kind      (req_kind),
        .head          (head),
        .addh          (addh),
        .addl          (addl),
        .sped          (sped),
        .chan          (chan),
        .option        (option),
        .cmd_busy      (cmd_busy),
        .process_done  (process_done),
        .reset_done    (reset_done),
        .check_done    (check_done),
        .process_start (process_start),
        .reset_start   (reset_start),
        .check_start   (check_start),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .seq_busy      (seq_busy),
        .aux           (aux)
    );

    wait_timer #(.limit(process_cycles)) process_timer (
        .mode3_clk (mode3_clk),
        .rst_n     (rst_n),
        .start     (process_start),
        .done      (process_done)
    );

    wait_timer #(.limit(reset_cycles)) reset_timer (
        .mode3_clk (mode3_clk),
        .rst_n     (rst_n),
        .start     (reset_start),
        .done      (reset_done)
    );

    wait_timer #(.limit(self_check_cycles)) check_timer (
        .mode3_clk (mode3_clk),
        .rst_n     (rst_n),
        .start     (check_start),
        .done      (check_done)
    );

endmodule

// ==== hdl/rf_timing_pkg.sv ====
package rf_timing_pkg;

    // Cycle counter used by the wait timers
    typedef logic [15:0] count_t;

    // Processing delay before a reply
    localparam count_t process_cycles = 16'd16;

    // Reset wait and the self-check that follows it
    localparam count_t reset_cycles      = 16'd64;
    localparam count_t self_check_cycles = 16'd32;

endpackage

// ==== hdl/wait_timer.sv ====
`timescale 1ns/1ps

module wait_timer
    import rf_timing_pkg::*;
#(
    parameter count_t limit = process_cycles
) (
    input  logic mode3_clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    count_t count;

    // Count while started and hold at the limit
    always_ff @(posedge mode3_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!start) begin
            count <= '0;
        end else if (count != limit) begin
            count <= count + 16'd1;
        end
    end

    // Stays high until start drops
    assign done = start && (count == limit);

endmodule

// ==== verification/tb_vectors.svh ====
`ifndef tb_vectors_svh
`define tb_vectors_svh

localparam int num_rows = 9;

// Command and reply bytes packed first byte in [47:40]
string       row_name    [num_rows];
logic [1:0]  row_mode    [num_rows];
int          row_ncmd    [num_rows];
logic [47:0] row_cmd     [num_rows];
int          row_nexp    [num_rows];
logic [47:0] row_exp     [num_rows];
byte_t       row_cfg     [num_rows];
int          row_min_low [num_rows];

task automatic put_row(input int r, input string name, input logic [1:0] mode,
                       input int n_cmd, input logic [47:0] cmd, input int n_exp,
                       input logic [47:0] exp_bytes, input byte_t cfg, input int min_low);
    row_name[r]    = name;
    row_mode[r]    = mode;
    row_ncmd[r]    = n_cmd;
    row_cmd[r]     = cmd;
    row_nexp[r]    = n_exp;
    row_exp[r]     = exp_bytes;
    row_cfg[r]     = cfg;
    row_min_low[r] = min_low;
endtask

task automatic build_table();
    logic [47:0] cfg_a;
    logic [47:0] cfg_b;
    logic [47:0] cfg_c;
    logic [47:0] read_cmd;
    int          i;
    cfg_a    = {cmd_load_keep, 40'h0};
    cfg_b    = {cmd_load_temp, 40'h0};
    cfg_c    = {cmd_load_keep, 40'h0};
    read_cmd = {cmd_read_config, cmd_read_config, cmd_read_config, 24'h0};
    // ADDH, ADDL, SPED, CHAN, OPTION
    for (i = 1; i < 6; i++) begin
        cfg_a[47 - 8*i -: 8] = next_byte();
        cfg_b[47 - 8*i -: 8] = next_byte();
        cfg_c[47 - 8*i -: 8] = next_byte();
    end
    put_row(0, "version_read", 2'd3, 3, {cmd_read_version, cmd_read_version,
            cmd_read_version, 24'h0}, 4, {32'hC3322702, 16'h0}, 8'h18, 0);
    put_row(1, "load_c0", 2'd3, 6, cfg_a, 6, cfg_a, cfg_a[23:16], 0);
    put_row(2, "load_c2", 2'd3, 6, cfg_b, 6, cfg_b, cfg_b[23:16], 0);
    put_row(3, "read_config", 2'd3, 3, read_cmd, 6, cfg_b, cfg_b[23:16], 0);
    put_row(4, "broken_triple", 2'd3, 3, {cmd_read_config, cmd_read_config, 8'h55, 24'h0},
            0, 48'h0, cfg_b[23:16], 0);
    put_row(5, "unknown_head", 2'd3, 1, {8'hA5, 40'h0}, 0, 48'h0, cfg_b[23:16], 0);
    // Full load while the mode pins select normal mode
    put_row(6, "load_wrong_mode", 2'd0, 6, cfg_c, 0, 48'h0, cfg_b[23:16], 0);
    put_row(7, "reset_cmd", 2'd3, 3, {cmd_reset, cmd_reset, cmd_reset, 24'h0}, 0, 48'h0,
            cfg_b[23:16], reset_cycles + self_check_cycles);
    put_row(8, "read_after_reset", 2'd3, 3, read_cmd, 6, cfg_b, cfg_b[23:16], 0);
endtask

`endif

// ==== verification/tb_rf_program_ctrl.sv ====
`timescale 1ns/1ps

module tb_rf_program_ctrl
    import rf_cmd_pkg::*;
    import rf_timing_pkg::*;
();

    // Longest wait for a reply after the last command byte
    localparam int collect_limit = process_cycles + reset_cycles + self_check_cycles + 30;

    logic  mode3_clk;
    logic  rst_n;
    logic  m0;
    logic  m1;
    logic  rx_valid;
    byte_t rx_data;
    logic  tx_valid;
    byte_t tx_data;
    byte_t uart_config;
    logic  aux;

    int          errors;
    int          checks;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] rng_state = 32'd39;

    rf_program_ctrl DUT (
        .mode3_clk   (mode3_clk),
        .rst_n       (rst_n),
        .m0          (m0),
        .m1          (m1),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .uart_config (uart_config),
        .aux         (aux)
    );

    always #4 mode3_clk = ~mode3_clk;

    function automatic byte_t next_byte();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[7:0];
    endfunction

    `include "tb_vectors.svh"

    task automatic run_row(input int r);
        byte_t got [6];
        byte_t exp_b;
        int    n_got;
        int    high_run;
        int    low_run;
        int    max_low;
        int    cycles;
        int    i;
        n_got    = 0;
        high_run = 0;
        low_run  = 0;
        max_low  = 0;
        cycles   = 0;
        @(posedge mode3_clk);
        m1 <= row_mode[r][1];
        m0 <= row_mode[r][0];
        // One idle cycle after every byte
        for (i = 0; i < row_ncmd[r]; i++) begin
            @(posedge mode3_clk);
            rx_valid <= 1'b1;
            rx_data  <= row_cmd[r][47 - 8*i -: 8];
            @(posedge mode3_clk);
            rx_valid <= 1'b0;
        end
        // Reply is over once aux has stayed high for 4 cycles
        while (high_run < 4 && cycles < collect_limit) begin
            @(negedge mode3_clk);
            cycles++;
            if (tx_valid) begin
                if (n_got < 6) begin
                    got[n_got] = tx_data;
                end
                n_got++;
            end
            if (aux) begin
                high_run++;
                low_run = 0;
            end else begin
                high_run = 0;
                low_run++;
                if (low_run > max_low) begin
                    max_low = low_run;
                end
            end
        end
        checks++;
        if (high_run < 4) begin
            $display("Test %s: aux did not return high within %0d cycles",
                     row_name[r], collect_limit);
            errors++;
        end
        checks++;
        if (n_got < row_nexp[r]) begin
            $display("Test %s: reply missing, got %0d of %0d bytes",
                     row_name[r], n_got, row_nexp[r]);
            errors++;
        end
        checks++;
        if (n_got > row_nexp[r]) begin
            $display("Test %s: %0d extra bytes sent", row_name[r], n_got - row_nexp[r]);
            errors++;
        end
        for (i = 0; i < row_nexp[r] && i < n_got && i < 6; i++) begin
            exp_b = row_exp[r][47 - 8*i -: 8];
            checks++;
            if (got[i] !== exp_b) begin
                $display("FAILED %s: reply byte %0d expected %h, actual %h",
                         row_name[r], i, exp_b, got[i]);
                errors++;
            end
        end
        checks++;
        if (uart_config !== row_cfg[r]) begin
            $display("FAILED %s: uart_config expected %h, actual %h",
                     row_name[r], row_cfg[r], uart_config);
            errors++;
        end
        if (row_min_low[r] > 0) begin
            checks++;
            if (max_low < row_min_low[r]) begin
                $display("Test %s: aux was low for only %0d cycles, at least %0d needed",
                         row_name[r], max_low, row_min_low[r]);
                errors++;
            end
        end
    endtask

    // Ends a run that has stopped making progress
    always @(posedge mode3_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int r;
        mode3_clk   = 1'b0;
        rst_n       = 1'b0;
        m0          = 1'b1;
        m1          = 1'b1;
        rx_valid    = 1'b0;
        rx_data     = 8'h00;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        build_table();
        cycle_limit = 12;
        for (r = 0; r < num_rows; r++) begin
            cycle_limit += row_ncmd[r] * 2 + process_cycles + reset_cycles
                           + self_check_cycles + 40;
        end
        repeat (4) @(posedge mode3_clk);
        rst_n <= 1'b1;
        @(negedge mode3_clk);
        checks++;
        if (aux !== 1'b1) begin
            $display("FAILED after_reset: aux expected 1, actual %b", aux);
            errors++;
        end
        checks++;
        if (tx_valid !== 1'b0) begin
            $display("FAILED after_reset: tx_valid expected 0, actual %b", tx_valid);
            errors++;
        end
        checks++;
        if (uart_config !== 8'h18) begin
            $display("FAILED after_reset: uart_config expected 18, actual %h", uart_config);
            errors++;
        end
        for (r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
